// File: imager_pkg.sv
/*
 * Shared types and constants for the parallel image sensor receiver.
 * dtype_t is 4 bits wide since its nine codes do not fit in three bits,
 * which makes a stream word 20 bits (type plus 16-bit data).
 * The data word is fixed at 16 bits to match the header words.
 */
package imager_pkg;

   typedef logic [15:0] data_word_t;
   typedef logic [15:0] dim_t;
   typedef logic [3:0]  reg_addr_t;

   typedef enum logic [3:0] {
      NONE,
      FRAME_START,
      ROW_START,
      PIXEL,
      ROW_END,
      FRAME_END,
      HEADER_START,
      HEADER,
      HEADER_END
   } dtype_t;

   typedef struct packed {
      dtype_t     dtype;
      data_word_t data;
   } stream_word_t;

   // synchronized levels and their one-cycle edges
   typedef struct packed {
      logic fv;
      logic lv;
      logic fv_rise;
      logic fv_fall;
      logic lv_rise;
      logic lv_fall;
   } line_state_t;

   // enable is bit 0 of the control register
   typedef struct packed {
      logic left_justify;
      logic test_pat;
      logic enable;
   } imager_cfg_t;

   typedef struct packed {
      dim_t        num_rows;
      dim_t        num_cols;
      logic [15:0] frame_count;
      logic [31:0] clks_per_frame;
      logic [15:0] clks_per_row;
      logic [15:0] checksum;
   } frame_stats_t;

   localparam int          HEADER_WORDS   = 10;
   localparam data_word_t  HEADER_VERSION = 16'd2;
   localparam logic [31:0] FRAME_MARKER   = 32'hFFFF_FFFE;

   typedef enum logic [1:0] {
      IDLE,
      START,
      BODY,
      END
   } header_state_t;

endpackage

// File: imager_regs.sv
/*
 * Control and status registers, all on clki.
 * Address 0 holds enable, test pattern and left justify in bits 2:0.
 * Address 1 reads the frame count. Any other address reads 16'hAAAA
 * with reg_err high, and writes to it are dropped.
 * Reads are combinational from reg_addr.
 */
`timescale 1ns/1ps

module imager_regs import imager_pkg::*; (
   input  logic        clki,
   input  logic        resetb_clki,
   input  reg_addr_t   reg_addr,
   input  logic        reg_write,
   input  data_word_t  reg_wdata,
   input  logic [15:0] frame_count,
   output data_word_t  reg_rdata,
   output logic        reg_err,
   output imager_cfg_t cfg
);

   localparam reg_addr_t ADDR_CTRL        = 4'd0;
   localparam reg_addr_t ADDR_FRAME_COUNT = 4'd1;

   always_ff @(posedge clki or negedge resetb_clki) begin
      if (!resetb_clki) begin
         cfg <= '0;
      end else if (reg_write && (reg_addr == ADDR_CTRL)) begin
         cfg <= imager_cfg_t'(reg_wdata[2:0]);
      end
   end

   // read decode
   always_comb begin
      reg_err = 1'b0;
      case (reg_addr)
         ADDR_CTRL: begin
            reg_rdata = data_word_t'(cfg);
         end
         ADDR_FRAME_COUNT: begin
            reg_rdata = frame_count;
         end
         default: begin
            // unmapped address
            reg_rdata = 16'hAAAA;
            reg_err   = 1'b1;
         end
      endcase
   end

endmodule

// File: sensor_sync.sv
/*
 * Input registers for the sensor pins, two stages deep.
 * Levels and pixel are seen on the second rising edge after a change.
 * Rise pulses come straight from the two stages; fall pulses are
 * delayed one more cycle so that the end events follow the last pixel.
 */
`timescale 1ns/1ps

module sensor_sync import imager_pkg::*; #(
   parameter int PIXEL_WIDTH = 12
) (
   input  logic                   clki,
   input  logic                   resetb_clki,
   input  logic                   fv,
   input  logic                   lv,
   input  logic [PIXEL_WIDTH-1:0] datai,
   output line_state_t            line,
   output logic [PIXEL_WIDTH-1:0] pixel
);

   logic                   fv_s, fv_ss, lv_s, lv_ss;
   logic                   fv_fall_d, lv_fall_d;
   logic [PIXEL_WIDTH-1:0] pix_s, pix_ss;

   always_ff @(posedge clki or negedge resetb_clki) begin
      if (!resetb_clki) begin
         fv_s      <= 1'b0;
         fv_ss     <= 1'b0;
         lv_s      <= 1'b0;
         lv_ss     <= 1'b0;
         pix_s     <= '0;
         pix_ss    <= '0;
         fv_fall_d <= 1'b0;
         lv_fall_d <= 1'b0;
      end else begin
         // pad stage
         fv_s      <= fv;
         lv_s      <= lv;
         pix_s     <= datai;
         fv_ss     <= fv_s;
         lv_ss     <= lv_s;
         pix_ss    <= pix_s;
         fv_fall_d <= !fv_s && fv_ss;
         lv_fall_d <= !lv_s && lv_ss;
      end
   end

   assign line = '{
      fv:      fv_ss,
      lv:      lv_ss,
      fv_rise: fv_s && !fv_ss,
      fv_fall: fv_fall_d,
      lv_rise: lv_s && !lv_ss,
      lv_fall: lv_fall_d
   };

   assign pixel = pix_ss;

endmodule

// File: frame_stats.sv
/*
 * Frame counters and the statistics record for the header.
 * Row index counts finished rows; column index counts valid pixels
 * of the current row. Both are live and feed the test pattern.
 * Clock counts start at reset, so clks_per_frame and clks_per_row
 * are only meaningful from the second frame and second row on.
 */
`timescale 1ns/1ps

module frame_stats import imager_pkg::*; (
   input  logic         clki,
   input  logic         resetb_clki,
   input  line_state_t  line,
   input  logic         pixel_valid,
   input  logic [15:0]  checksum,
   output dim_t         row_idx,
   output dim_t         col_idx,
   output frame_stats_t stats
);

   dim_t        num_rows, num_cols;
   logic [15:0] frame_count;
   logic [31:0] frame_clks, clks_per_frame;
   logic [15:0] row_clks, clks_per_row;
   logic        in_frame;

   // the rise pulse arrives one cycle before the fv level
   assign in_frame = line.fv || line.fv_rise;

   always_ff @(posedge clki or negedge resetb_clki) begin
      if (!resetb_clki) begin
         frame_count    <= '0;
         frame_clks     <= '0;
         clks_per_frame <= '0;
         row_idx        <= '0;
         col_idx        <= '0;
         num_rows       <= '0;
         num_cols       <= '0;
         row_clks       <= '0;
         clks_per_row   <= '0;
      end else begin
         if (line.fv_rise) begin
            frame_count    <= frame_count + 16'd1;
            frame_clks     <= '0;
            clks_per_frame <= frame_clks + 32'd1;
            row_idx        <= '0;
         end else begin
            frame_clks <= frame_clks + 32'd1;
            if (line.lv_fall) begin
               row_idx <= row_idx + 16'd1;
            end
         end

         if (line.lv_rise) begin
            col_idx <= '0;
         end else if (pixel_valid) begin
            col_idx <= col_idx + 16'd1;
         end

         // count the last row too when fv and lv drop together
         if (line.fv_fall) begin
            num_rows <= line.lv_fall ? row_idx + 16'd1 : row_idx;
            num_cols <= col_idx;
         end

         if (in_frame) begin
            if (line.lv_rise) begin
               row_clks     <= '0;
               clks_per_row <= row_clks + 16'd1;
            end else begin
               row_clks <= row_clks + 16'd1;
            end
         end
      end
   end

   assign stats = '{
      num_rows:       num_rows,
      num_cols:       num_cols,
      frame_count:    frame_count,
      clks_per_frame: clks_per_frame,
      clks_per_row:   clks_per_row,
      checksum:       checksum
   };

endmodule

// File: header_words.sv
/*
 * Header word read port with one cycle of latency.
 * Indices 0 to 9 follow the fixed header layout; higher ones read 0.
 * The record is read live, so a header held back past the next
 * frame start picks up that frame's counters.
 */
`timescale 1ns/1ps

module header_words import imager_pkg::*; (
   input  logic         clki,
   input  logic         resetb_clki,
   input  frame_stats_t stats,
   input  logic [3:0]   index,
   output data_word_t   word
);

   data_word_t word_next;

   always_comb begin
      case (index)
         4'd0:    word_next = FRAME_MARKER[15:0];
         4'd1:    word_next = FRAME_MARKER[31:16];
         4'd2:    word_next = HEADER_VERSION;
         4'd3:    word_next = stats.num_rows;
         4'd4:    word_next = stats.num_cols;
         4'd5:    word_next = stats.frame_count;
         4'd6:    word_next = stats.clks_per_frame[15:0];
         4'd7:    word_next = stats.clks_per_frame[31:16];
         4'd8:    word_next = stats.clks_per_row;
         4'd9:    word_next = stats.checksum;
         default: word_next = '0;
      endcase
   end

   always_ff @(posedge clki or negedge resetb_clki) begin
      if (!resetb_clki) begin
         word <= '0;
      end else begin
         word <= word_next;
      end
   end

endmodule

// File: stream_emitter.sv
/*
 * Builds the typed output stream from the synchronized sensor signals.
 * Two register stages: the first picks the highest priority sensor event,
 * the second merges it with the header block. Pixels leave three edges
 * after the pad register first samples them.
 * Sensor events always win over header words, even while stalled.
 * PIXEL_WIDTH must not exceed 16.
 */
`timescale 1ns/1ps

module stream_emitter import imager_pkg::*; #(
   parameter int PIXEL_WIDTH = 12
) (
   input  logic                   clki,
   input  logic                   resetb_clki,
   input  imager_cfg_t            cfg,
   input  line_state_t            line,
   input  logic [PIXEL_WIDTH-1:0] pixel,
   input  dim_t                   row_idx,
   input  dim_t                   col_idx,
   input  logic [15:0]            frame_count,
   input  data_word_t             header_word,
   input  logic                   header_stall,
   output logic [3:0]             header_index,
   output logic [15:0]            checksum,
   output logic                   pixel_valid,
   output logic                   dvo,
   output stream_word_t           stream
);

   logic                   stall_s, wait_fv, fv_d1, fv_d2;
   logic                   active, take, ev_frame_end;
   dim_t                   pat_sum;
   logic [PIXEL_WIDTH-1:0] pix_sel;
   data_word_t             pix_word;
   stream_word_t           ev, ev_next;
   header_state_t          state;
   logic [3:0]             hdr_cnt;

   assign pixel_valid = line.fv && line.lv;
   assign active      = cfg.enable && !wait_fv;

   // test pattern is row plus column, truncated
   assign pat_sum  = row_idx + col_idx;
   assign pix_sel  = cfg.test_pat ? pat_sum[PIXEL_WIDTH-1:0] : pixel;
   assign pix_word = cfg.left_justify ?
                     data_word_t'(pix_sel) << ($bits(data_word_t) - PIXEL_WIDTH) :
                     data_word_t'(pix_sel);

   // event priority, highest first
   always_comb begin
      ev_next = '{dtype: NONE, data: '0};
      if (pixel_valid) begin
         ev_next = '{dtype: PIXEL, data: pix_word};
      end else if (line.fv_rise) begin
         ev_next = '{dtype: FRAME_START, data: frame_count};
      end else if (line.fv_fall) begin
         ev_next = '{dtype: FRAME_END, data: '0};
      end else if (line.lv_rise) begin
         ev_next = '{dtype: ROW_START, data: row_idx};
      end else if (line.lv_fall) begin
         ev_next = '{dtype: ROW_END, data: '0};
      end
   end

   assign ev_frame_end = (ev.dtype == FRAME_END);
   assign take         = active && (ev.dtype == NONE) && (state == BODY);

   // index of the word wanted after this edge, so the read port keeps up
   always_comb begin
      header_index = hdr_cnt;
      if (!active || ev_frame_end) begin
         header_index = '0;
      end else if (take) begin
         header_index = hdr_cnt + 4'd1;
      end
   end

   always_ff @(posedge clki or negedge resetb_clki) begin
      if (!resetb_clki) begin
         stall_s  <= 1'b0;
         wait_fv  <= 1'b1;
         fv_d1    <= 1'b0;
         fv_d2    <= 1'b0;
         ev       <= '0;
         checksum <= '0;
      end else begin
         stall_s <= header_stall;
         fv_d1   <= line.fv;
         fv_d2   <= fv_d1;
         // fv low for three samples and no frame starting
         if (!cfg.enable) begin
            wait_fv <= 1'b1;
         end else if (!line.fv && !fv_d1 && !fv_d2 && !line.fv_rise) begin
            wait_fv <= 1'b0;
         end
         ev <= active ? ev_next : '0;
         if (active && (ev_next.dtype == PIXEL)) begin
            checksum <= checksum + pix_word;
         end else if (active && (ev_next.dtype == FRAME_START)) begin
            checksum <= '0;
         end
      end
   end

   always_ff @(posedge clki or negedge resetb_clki) begin
      if (!resetb_clki) begin
         dvo     <= 1'b0;
         stream  <= '0;
         state   <= IDLE;
         hdr_cnt <= '0;
      end else begin
         hdr_cnt <= header_index;
         dvo     <= 1'b0;
         stream  <= '0;
         if (!active) begin
            state <= IDLE;
         end else if (ev.dtype != NONE) begin
            dvo    <= 1'b1;
            stream <= ev;
            if (ev_frame_end) begin
               state <= START;
            end
         end else begin
            case (state)
               START: begin
                  // wait here while downstream is busy
                  if (!stall_s) begin
                     dvo    <= 1'b1;
                     stream <= '{dtype: HEADER_START, data: '0};
                     state  <= BODY;
                  end
               end
               BODY: begin
                  dvo    <= 1'b1;
                  stream <= '{dtype: HEADER, data: header_word};
                  if (hdr_cnt == 4'(HEADER_WORDS - 1)) begin
                     state <= END;
                  end
               end
               END: begin
                  dvo    <= 1'b1;
                  stream <= '{dtype: HEADER_END, data: '0};
                  state  <= IDLE;
               end
               default: begin
                  state <= IDLE;
               end
            endcase
         end
      end
   end

endmodule

// File: imager_rx.sv
/*
 * Parallel image sensor receiver, single clock domain on clki.
 * Emits a typed 16-bit word stream strobed by dvo, with a statistics
 * header after every frame end. header_stall is the only back-pressure
 * and holds only the header start; there is no output handshake.
 */
`timescale 1ns/1ps

module imager_rx import imager_pkg::*; #(
   parameter int PIXEL_WIDTH = 12
) (
   input  logic                   clki,
   input  logic                   resetb_clki,
   input  reg_addr_t              reg_addr,
   input  logic                   reg_write,
   input  data_word_t             reg_wdata,
   output data_word_t             reg_rdata,
   output logic                   reg_err,
   input  logic                   fv,
   input  logic                   lv,
   input  logic [PIXEL_WIDTH-1:0] datai,
   input  logic                   header_stall,
   output logic                   dvo,
   output stream_word_t           stream
);

   imager_cfg_t            cfg;
   line_state_t            line;
   logic [PIXEL_WIDTH-1:0] pixel;
   frame_stats_t           stats;
   dim_t                   row_idx, col_idx;
   logic [15:0]            checksum;
   logic                   pixel_valid;
   logic [3:0]             header_index;
   data_word_t             header_word;

   imager_regs u_regs (
      .clki        (clki),
      .resetb_clki (resetb_clki),
      .reg_addr    (reg_addr),
      .reg_write   (reg_write),
      .reg_wdata   (reg_wdata),
      .frame_count (stats.frame_count),
      .reg_rdata   (reg_rdata),
      .reg_err     (reg_err),
      .cfg         (cfg)
   );

   sensor_sync #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_sync (
      .clki        (clki),
      .resetb_clki (resetb_clki),
      .fv          (fv),
      .lv          (lv),
      .datai       (datai),
      .line        (line),
      .pixel       (pixel)
   );

   frame_stats u_stats (
      .clki        (clki),
      .resetb_clki (resetb_clki),
      .line        (line),
      .pixel_valid (pixel_valid),
      .checksum    (checksum),
      .row_idx     (row_idx),
      .col_idx     (col_idx),
      .stats       (stats)
   );

   header_words u_header (
      .clki        (clki),
      .resetb_clki (resetb_clki),
      .stats       (stats),
      .index       (header_index),
      .word        (header_word)
   );

   stream_emitter #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_emitter (
      .clki         (clki),
      .resetb_clki  (resetb_clki),
      .cfg          (cfg),
      .line         (line),
      .pixel        (pixel),
      .row_idx      (row_idx),
      .col_idx      (col_idx),
      .frame_count  (stats.frame_count),
      .header_word  (header_word),
      .header_stall (header_stall),
      .header_index (header_index),
      .checksum     (checksum),
      .pixel_valid  (pixel_valid),
      .dvo          (dvo),
      .stream       (stream)
   );

endmodule

// File: imager_rx_checker.sv
/*
 * Assertions on the stream emitter, bound into every instance.
 * The stall rule only holds when no sensor event is pending, since
 * sensor events take the output even while the header waits.
 */
`timescale 1ns/1ps

module imager_rx_checker import imager_pkg::*; (
   input logic          clki,
   input logic          resetb_clki,
   input imager_cfg_t   cfg,
   input header_state_t state,
   input logic          stall_s,
   input stream_word_t  ev,
   input logic          dvo,
   input stream_word_t  stream
);

   // output quiet while disabled
   a_quiet_disabled: assert property (
      @(posedge clki) disable iff (!resetb_clki) !cfg.enable |=> !dvo
   ) else $error("dvo high while disabled");

   a_quiet_stalled: assert property (
      @(posedge clki) disable iff (!resetb_clki)
      (state == START) && stall_s && (ev.dtype == NONE) |=> !dvo
   ) else $error("dvo high while header start is stalled");

   a_valid_type: assert property (
      @(posedge clki) disable iff (!resetb_clki) dvo |-> (stream.dtype != NONE)
   ) else $error("valid word carries type NONE");

endmodule

bind stream_emitter imager_rx_checker u_checker (
   .clki        (clki),
   .resetb_clki (resetb_clki),
   .cfg         (cfg),
   .state       (state),
   .stall_s     (stall_s),
   .ev          (ev),
   .dvo         (dvo),
   .stream      (stream)
);

// File: tb_imager_rx.sv
/*
 * Testbench for imager_rx: sensor model, register accesses, reference
 * model of the word stream and an in-order comparator.
 * Frames keep at least two rows and gaps of three or more cycles, so
 * row and frame edges never coincide except where a test wants it.
 * The frame counter counts every fv rise, enabled or not.
 */
`timescale 1ns/1ps

module tb_imager_rx;
   import imager_pkg::*;

   localparam int PIXEL_WIDTH  = 12;
   localparam int CLK_PERIOD   = 4;
   localparam int MAX_ROWS     = 6;
   localparam int MAX_COLS     = 10;
   localparam int WATCHDOG_CYC = 12 * (MAX_ROWS * (MAX_COLS + 8) + 120) + 600;

   logic                   clki, resetb_clki;
   reg_addr_t              reg_addr;
   logic                   reg_write;
   data_word_t             reg_wdata, reg_rdata;
   logic                   reg_err;
   logic                   fv, lv, header_stall, dvo;
   logic [PIXEL_WIDTH-1:0] datai;
   stream_word_t           stream;

   logic [31:0]            lfsr_state = 32'h7f85_f4ed;
   logic [PIXEL_WIDTH-1:0] pix_mem [MAX_ROWS*MAX_COLS];
   int                     row_rise [MAX_ROWS];
   logic [19:0]            exp_q[$], mask_q[$], obs_q[$];
   int                     cyc, errors, obs_count, frames_driven, prev_rise;
   bit                     have_prev, cur_test_pat, cur_left;

   imager_rx #(.PIXEL_WIDTH(PIXEL_WIDTH)) UUT (.*);

   initial begin
      clki = 1'b0;
      forever #(CLK_PERIOD / 2) clki = ~clki;
   end

   always @(posedge clki) cyc <= cyc + 1;

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   function automatic void expect_word(input dtype_t t, input data_word_t d,
                                       input data_word_t mask);
      exp_q.push_back({t, d});
      mask_q.push_back({4'hF, mask});
   endfunction

   // expected words of one enabled frame, returns the sum of its pixel words
   function automatic data_word_t build_expected(input int rows, input int cols,
                                                 input bit together);
      logic [PIXEL_WIDTH-1:0] val;
      data_word_t             w, sum;
      sum = '0;
      expect_word(FRAME_START, 16'(frames_driven), 16'hFFFF);
      for (int r = 0; r < rows; r++) begin
         // a frame start hides the row start of the same cycle
         if (!(together && r == 0)) expect_word(ROW_START, 16'(r), 16'hFFFF);
         for (int c = 0; c < cols; c++) begin
            val = cur_test_pat ? PIXEL_WIDTH'(r + c) : pix_mem[r*cols + c];
            w = cur_left ? 16'(val) << (16 - PIXEL_WIDTH) : 16'(val);
            sum = sum + w;
            expect_word(PIXEL, w, 16'hFFFF);
         end
         expect_word(ROW_END, 16'h0, 16'hFFFF);
      end
      expect_word(FRAME_END, 16'h0, 16'hFFFF);
      return sum;
   endfunction

   // header block that follows the frame just driven
   function automatic void append_header(input int rows, input int cols,
                                         input logic [31:0] cpf, input bit cpf_valid,
                                         input logic [15:0] cpr, input data_word_t sum);
      data_word_t cpf_mask;
      cpf_mask = cpf_valid ? 16'hFFFF : 16'h0000;
      expect_word(HEADER_START, 16'h0, 16'hFFFF);
      expect_word(HEADER, 16'hFFFE, 16'hFFFF);
      expect_word(HEADER, 16'hFFFF, 16'hFFFF);
      expect_word(HEADER, 16'd2, 16'hFFFF);
      expect_word(HEADER, 16'(rows), 16'hFFFF);
      expect_word(HEADER, 16'(cols), 16'hFFFF);
      expect_word(HEADER, 16'(frames_driven), 16'hFFFF);
      expect_word(HEADER, cpf[15:0], cpf_mask);
      expect_word(HEADER, cpf[31:16], cpf_mask);
      expect_word(HEADER, cpr, 16'hFFFF);
      expect_word(HEADER, sum, 16'hFFFF);
      expect_word(HEADER_END, 16'h0, 16'hFFFF);
   endfunction

   task automatic idle(input int n);
      repeat (n) @(negedge clki);
   endtask

   task automatic write_reg(input reg_addr_t a, input data_word_t d);
      @(negedge clki);
      reg_addr  = a;
      reg_wdata = d;
      reg_write = 1'b1;
      @(negedge clki);
      reg_write = 1'b0;
   endtask

   task automatic read_check(input reg_addr_t a, input data_word_t d, input logic e);
      @(negedge clki);
      reg_addr = a;
      @(posedge clki);
      check_value("reg_rdata", 32'(reg_rdata), 32'(d));
      check_value("reg_err", 32'(reg_err), 32'(e));
   endtask

   task automatic set_mode(input bit en, input bit tp, input bit lj);
      cur_test_pat = tp;
      cur_left     = lj;
      write_reg(4'd0, {13'd0, lj, tp, en});
   endtask

   // sensor model; en_row >= 0 writes enable after that row
   task automatic drive_frame(input int rows, input int cols, input bit together,
                              input int en_row, input bit expect_words);
      int          gap, rise;
      logic [31:0] cpf;
      bit          cpf_valid;
      data_word_t  sum;
      sum = '0;
      for (int i = 0; i < rows * cols; i++) pix_mem[i] = PIXEL_WIDTH'(rand_bits(PIXEL_WIDTH));
      // frame words are known up front, the header needs the driven timing
      if (expect_words) sum = build_expected(rows, cols, together);
      if (!together) begin
         @(negedge clki);
         fv   = 1'b1;
         rise = cyc;
         idle(3);
      end
      for (int r = 0; r < rows; r++) begin
         for (int c = 0; c < cols; c++) begin
            @(negedge clki);
            lv    = 1'b1;
            datai = pix_mem[r*cols + c];
            if (c == 0) row_rise[r] = cyc;
            if (together && r == 0 && c == 0) begin
               fv   = 1'b1;
               rise = cyc;
            end
         end
         @(negedge clki);
         lv    = 1'b0;
         datai = '0;
         gap   = 3 + int'(rand_bits(2));
         if (r == en_row) write_reg(4'd0, 16'h0001);
         idle(gap);
      end
      fv = 1'b0;
      frames_driven++;
      cpf_valid = have_prev;
      cpf       = 32'(rise - prev_rise);
      prev_rise = rise;
      have_prev = 1'b1;
      if (expect_words) begin
         append_header(rows, cols, cpf, cpf_valid,
                       16'(row_rise[rows-1] - row_rise[rows-2]), sum);
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() > 0) @(negedge clki);
      idle(4);
   endtask

   // monitor
   always @(negedge clki) begin
      if (resetb_clki && dvo) begin
         obs_q.push_back(stream);
         obs_count++;
      end
   end

   // comparator
   always @(negedge clki) begin
      while (obs_q.size() > 0) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected output word %h when no word was expected", obs_q.pop_front());
         end else begin
            check_value("stream", 32'(obs_q.pop_front() & mask_q[0]),
                        32'(exp_q.pop_front() & mask_q[0]));
            void'(mask_q.pop_front());
         end
      end
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Watchdog expired with %0d words still expected, errors: %0d",
               exp_q.size(), errors);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      int snap;
      cyc = 0;
      errors = 0;
      obs_count = 0;
      frames_driven = 0;
      have_prev = 1'b0;
      resetb_clki = 1'b0;
      reg_addr = '0;
      reg_write = 1'b0;
      reg_wdata = '0;
      fv = 1'b0;
      lv = 1'b0;
      datai = '0;
      header_stall = 1'b0;
      cur_test_pat = 1'b0;
      cur_left = 1'b0;
      idle(4);
      resetb_clki = 1'b1;

      // registers
      read_check(4'd0, 16'h0000, 1'b0);
      write_reg(4'd0, 16'hFFFA);
      read_check(4'd0, 16'h0002, 1'b0);
      write_reg(4'd0, 16'h0000);
      read_check(4'd1, 16'h0000, 1'b0);
      for (int a = 2; a < 16; a++) begin
         write_reg(reg_addr_t'(a), 16'h0007);
         read_check(reg_addr_t'(a), 16'hAAAA, 1'b1);
      end
      read_check(4'd0, 16'h0000, 1'b0);

      // plain frames, right justified
      set_mode(1'b1, 1'b0, 1'b0);
      idle(8);
      drive_frame(4, 8, 1'b0, -1, 1'b1);
      idle(30);
      drive_frame(3, 6, 1'b0, -1, 1'b1);
      wait_drain();

      set_mode(1'b1, 1'b0, 1'b1);
      drive_frame(3, 5, 1'b0, -1, 1'b1);
      wait_drain();
      set_mode(1'b1, 1'b1, 1'b0);
      drive_frame(4, 7, 1'b0, -1, 1'b1);
      wait_drain();

      // enable lands in the middle of a frame
      set_mode(1'b0, 1'b0, 1'b0);
      drive_frame(5, 6, 1'b0, 1, 1'b0);
      idle(20);
      drive_frame(3, 5, 1'b1, -1, 1'b1);
      wait_drain();

      // header held back by stall
      header_stall = 1'b1;
      drive_frame(3, 4, 1'b0, -1, 1'b1);
      idle(12);
      snap = obs_count;
      idle(8 + int'(rand_bits(4)));
      if (obs_count != snap) begin
         errors++;
         $display("Words appeared while the header was stalled");
      end
      header_stall = 1'b0;
      wait_drain();

      read_check(4'd1, 16'(frames_driven), 1'b0);
      if (exp_q.size() != 0 || obs_q.size() != 0) begin
         errors++;
         $display("Streams out of step at the end of the run");
      end
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: verilog.f
imager_pkg.sv
imager_regs.sv
sensor_sync.sv
frame_stats.sv
header_words.sv
stream_emitter.sv
imager_rx.sv
imager_rx_checker.sv
tb_imager_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the imager_rx testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_imager_rx -f verilog.f -o sim_tb_imager_rx
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb_imager_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
